// File: uart_core.f
+incdir+src
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_baud_gen.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_core.sv
tests/uart_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the UART core testbench with Verilator and runs it
# exit status 0 only when the run prints the pass line

set -u
cd "$(dirname "$0")" || exit 1

top=uart_core_tb
build_dir=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module "$top" -Mdir "$build_dir" -o sim -f uart_core.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$("./$build_dir/sim")
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi

// File: tests/uart_core_tb.sv
// self-checking testbench for the UART core
// sends bytes through the transmitter in loopback or from a serial line
// driver, keeps a reference byte queue and compares every rx transfer
// built and run by run_sim.sh with the uart_core.f file list

`timescale 1ns/100ps

`include "uart_params.svh"

module uart_core_tb;

  localparam int frames_per_test = 12;
  localparam int num_tests       = 6;
  localparam int max_div         = 13;
  localparam int timeout_cycles  = frames_per_test * num_tests * 10 * max_div + 2000;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   en_i;
  logic [`UART_DIV_W-1:0] baud_div_i;
  uart_pkg::byte_t        tx_data_i;
  logic                   tx_valid_i;
  logic                   tx_ready_o;
  uart_pkg::byte_t        rx_data_o;
  logic                   rx_valid_o;
  logic                   rx_ready_i;
  logic                   tx_o;
  logic                   rx_i;
  logic                   frame_err_o;
  logic                   overrun_o;

  logic            loop_en;   // rx_i from tx_o when high
  logic            drv_line;  // serial driver output
  logic            rand_rdy;  // random rx_ready_i each cycle
  logic [31:0]     rng;
  int              cur_div;
  string           test_name;
  uart_pkg::byte_t exp_mem [64];  // reference byte queue
  logic [5:0]      exp_head = '0;
  logic [5:0]      exp_tail = '0;
  int              err_cnt = 0;
  int              cmp_err_cnt = 0;
  int              fe_cnt = 0;
  int              ov_cnt = 0;
  int              cycle_cnt = 0;

  assign rx_i = loop_en ? tx_o : drv_line;

  uart_core uart_core_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (en_i),
    .baud_div_i (baud_div_i),
    .tx_data_i  (tx_data_i),
    .tx_valid_i (tx_valid_i),
    .tx_ready_o (tx_ready_o),
    .rx_data_o  (rx_data_o),
    .rx_valid_o (rx_valid_o),
    .rx_ready_i (rx_ready_i),
    .tx_o       (tx_o),
    .rx_i       (rx_i),
    .frame_err_o(frame_err_o),
    .overrun_o  (overrun_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  // ============================================================
  // reference model
  // ============================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic uart_pkg::byte_t random_byte();
    rng = xorshift32(rng);
    return rng[7:0];
  endfunction

  // bit k of an 8N1 frame where k = 0 is the start bit
  function automatic logic frame_bit(input uart_pkg::byte_t b, input int k);
    uart_pkg::byte_t s;
    if (k == 0) return 1'b0;
    if (k > 8) return 1'b1;  // stop
    s = b >> (k - 1);  // LSB first
    return s[0];
  endfunction

  // ============================================================
  // comparator and status counters
  // ============================================================
  always @(negedge clk_i) begin
    if (rst_ni && rx_valid_o && rx_ready_i) begin
      assert (exp_head != exp_tail) else begin
        cmp_err_cnt++;
        $display("%s: byte %02h came out of the receiver but none was sent", test_name,
                 rx_data_o);
      end
      if (exp_head != exp_tail) begin
        assert (rx_data_o == exp_mem[exp_head]) else begin
          cmp_err_cnt++;
          $display("MISMATCH %s rx byte: expected %02h actual %02h", test_name,
                   exp_mem[exp_head], rx_data_o);
        end
        exp_head <= exp_head + 6'd1;  // pop as the transfer happens at the next edge
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && frame_err_o) fe_cnt <= fe_cnt + 1;
    if (rst_ni && overrun_o) ov_cnt <= ov_cnt + 1;
  end

  initial begin
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("errors: %0d in checks, %0d in receive compare", err_cnt, cmp_err_cnt);
    $display("Result: FAILED");
    $finish;
  end

  // ============================================================
  // helpers
  // ============================================================
  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      err_cnt++;
      $display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  // advance to 1 ns after the next rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
    if (rand_rdy) begin
      rng = xorshift32(rng);
      rx_ready_i = rng[7];
    end
  endtask

  task automatic set_div(input int div);
    cur_div = div;
    baud_div_i = cur_div[`UART_DIV_W-1:0];
  endtask

  task automatic expect_byte(input uart_pkg::byte_t b);
    exp_mem[exp_tail] = b;
    exp_tail = exp_tail + 6'd1;
  endtask

  task automatic send_tx(input uart_pkg::byte_t b);
    tx_data_i  = b;
    tx_valid_i = 1'b1;
    @(negedge clk_i);
    while (!tx_ready_o) begin
      step();
      @(negedge clk_i);
    end
    step();  // transfer edge
    tx_valid_i = 1'b0;
  endtask

  // serial driver sending one bit per cur_div cycles
  task automatic drive_frame(input uart_pkg::byte_t b, input logic stop_bit);
    for (int k = 0; k < 9; k++) begin
      drv_line = frame_bit(b, k);
      repeat (cur_div) step();
    end
    drv_line = stop_bit;
    repeat (cur_div) step();
    drv_line = 1'b1;
  endtask

  task automatic wait_tx_done();
    @(negedge clk_i);
    while (!tx_ready_o) begin
      step();
      @(negedge clk_i);
    end
    repeat (2 * cur_div) step();  // receiver lags the line
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    while (exp_head != exp_tail || rx_valid_o) begin
      step();
      @(negedge clk_i);
    end
    step();
  endtask

  // ============================================================
  // tests
  // ============================================================
  task automatic run_tx_timing();
    uart_pkg::byte_t b;
    b = random_byte();
    loop_en    = 1'b0;  // receiver sees the idle driver line
    tx_data_i  = b;
    tx_valid_i = 1'b1;
    @(negedge clk_i);
    check_value("tx_ready before transfer", 1, int'(tx_ready_o));
    step();
    tx_valid_i = 1'b0;
    for (int c = 0; c < 10 * cur_div; c++) begin
      @(negedge clk_i);
      if (c % cur_div == cur_div / 2) begin
        check_value($sformatf("tx bit %0d", c / cur_div), int'(frame_bit(b, c / cur_div)),
                    int'(tx_o));
      end
      check_value($sformatf("tx_ready at cycle %0d", c), (c == 10 * cur_div - 1) ? 1 : 0,
                  int'(tx_ready_o));
    end
    step();
    loop_en = 1'b1;
  endtask

  initial begin
    int fe0;
    int ov0;
    uart_pkg::byte_t b;
    rst_ni     = 1'b0;
    en_i       = 1'b1;
    tx_data_i  = '0;
    tx_valid_i = 1'b0;
    rx_ready_i = 1'b1;
    loop_en    = 1'b0;  // tx_o unknown until the first reset edge
    drv_line   = 1'b1;
    rand_rdy   = 1'b0;
    rng        = 32'h374c;
    test_name  = "reset";
    set_div(8);
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    @(negedge clk_i);
    check_value("tx_o", 1, int'(tx_o));
    check_value("tx_ready_o", 1, int'(tx_ready_o));
    check_value("rx_valid_o", 0, int'(rx_valid_o));
    check_value("status pulses", 0, int'(frame_err_o) + int'(overrun_o));
    step();

    test_name = "loopback";
    loop_en = 1'b1;
    fe0 = fe_cnt;
    ov0 = ov_cnt;
    for (int i = 0; i < 20; i++) begin
      b = random_byte();
      expect_byte(b);
      send_tx(b);
    end
    wait_drain();
    check_value("frame errors", 0, fe_cnt - fe0);
    check_value("overruns", 0, ov_cnt - ov0);

    test_name = "tx_timing";
    run_tx_timing();

    test_name = "overrun";
    rx_ready_i = 1'b0;  // let the FIFO fill
    ov0 = ov_cnt;
    for (int i = 0; i < `UART_FIFO_DEPTH + 2; i++) begin
      b = random_byte();
      if (i < `UART_FIFO_DEPTH) expect_byte(b);
      send_tx(b);
    end
    wait_tx_done();
    check_value("overrun pulses", 2, ov_cnt - ov0);
    rx_ready_i = 1'b1;
    wait_drain();
    check_value("overrun pulses after drain", 2, ov_cnt - ov0);

    test_name = "frame_err";
    loop_en = 1'b0;
    fe0 = fe_cnt;
    ov0 = ov_cnt;
    drive_frame(random_byte(), 1'b0);
    repeat (2 * cur_div) step();
    check_value("frame error pulses", 1, fe_cnt - fe0);
    rx_ready_i = 1'b0;  // a false byte would stay visible
    drv_line   = 1'b0;  // quarter-period glitch
    repeat (cur_div / 4) step();
    drv_line = 1'b1;
    repeat (11 * cur_div) step();  // longer than a whole frame
    check_value("rx_valid after glitch", 0, int'(rx_valid_o));
    check_value("frame errors after glitch", 1, fe_cnt - fe0);
    rx_ready_i = 1'b1;
    b = random_byte();
    expect_byte(b);
    drive_frame(b, 1'b1);
    wait_drain();
    check_value("frame errors after good frame", 1, fe_cnt - fe0);
    check_value("overruns", 0, ov_cnt - ov0);
    loop_en = 1'b1;

    test_name = "backpressure";
    set_div(13);
    fe0 = fe_cnt;
    ov0 = ov_cnt;
    rand_rdy = 1'b1;
    for (int i = 0; i < 12; i++) begin
      b = random_byte();
      expect_byte(b);
      send_tx(b);
    end
    wait_drain();
    rand_rdy   = 1'b0;
    rx_ready_i = 1'b1;
    check_value("frame errors", 0, fe_cnt - fe0);
    check_value("overruns", 0, ov_cnt - ov0);

    $display("errors: %0d in checks, %0d in receive compare", err_cnt, cmp_err_cnt);
    if (err_cnt == 0 && cmp_err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: src/uart_core.sv
// top level of the UART peripheral core
// one shared baud divisor, a transmitter fed by a valid/ready byte port
// and a receiver whose FIFO drains through a second valid/ready port
// en_i low parks both sides idle with the line high

`timescale 1ns/100ps

`include "uart_params.svh"

module uart_core (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // configuration
  input  logic                   en_i,
  input  logic [`UART_DIV_W-1:0] baud_div_i,  // clk cycles per bit
  // transmit bytes
  input  uart_pkg::byte_t        tx_data_i,
  input  logic                   tx_valid_i,
  output logic                   tx_ready_o,
  // receive bytes
  output uart_pkg::byte_t        rx_data_o,
  output logic                   rx_valid_o,
  input  logic                   rx_ready_i,
  // serial lines
  output logic                   tx_o,
  input  logic                   rx_i,
  // status pulses
  output logic                   frame_err_o,
  output logic                   overrun_o
);

  logic baud_tick;
  logic tx_busy;  // frame in flight, counter runs

  // ============================================================
  // transmit path
  // ============================================================
  uart_baud_gen uart_baud_gen_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .baud_div_i(baud_div_i),
    .run_i     (tx_busy),
    .tick_o    (baud_tick)
  );

  uart_tx uart_tx_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (en_i),
    .baud_tick_i(baud_tick),
    .data_i     (tx_data_i),
    .valid_i    (tx_valid_i),
    .ready_o    (tx_ready_o),
    .busy_o     (tx_busy),
    .tx_o       (tx_o)
  );

  // receive path, own phase timing
  uart_rx uart_rx_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (en_i),
    .baud_div_i (baud_div_i),
    .rx_i       (rx_i),
    .data_o     (rx_data_o),
    .valid_o    (rx_valid_o),
    .ready_i    (rx_ready_i),
    .frame_err_o(frame_err_o),
    .overrun_o  (overrun_o)
  );

endmodule

// File: src/uart_rx.sv
// UART receiver, 8N1, with its receive FIFO
// times each bit from the start edge and samples mid-bit; a start bit that
// is high again at mid-bit is dropped as a glitch
// a low stop bit pulses frame_err_o, a byte arriving on a full FIFO
// pulses overrun_o and is lost

`timescale 1ns/100ps

`include "uart_params.svh"

module uart_rx (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic [`UART_DIV_W-1:0] baud_div_i,
  input  logic                   rx_i,  // async serial line
  output uart_pkg::byte_t        data_o,
  output logic                   valid_o,
  input  logic                   ready_i,
  output logic                   frame_err_o,
  output logic                   overrun_o
);

  localparam int unsigned bit_cnt_w = $clog2(`UART_DATA_W);
  localparam logic [bit_cnt_w-1:0] last_bit = bit_cnt_w'(`UART_DATA_W - 1);

  uart_pkg::rx_state_e     state_q;
  logic [1:0]              sync_q;
  logic                    rx_prev_q;
  logic                    rx_s;
  logic                    start_edge;
  logic [`UART_DIV_W-1:0]  phase_q;
  logic [`UART_DIV_W-1:0]  half_last;
  logic [`UART_DIV_W-1:0]  full_last;
  logic                    data_smp;
  logic                    stop_smp;
  logic [bit_cnt_w-1:0]    bit_cnt_q;
  uart_pkg::byte_t         shift_q;
  logic                    stop_q;
  logic                    done_q;  // cycle after the stop sample
  logic                    fifo_wr;
  logic                    fifo_rd;
  logic                    fifo_full;
  logic                    fifo_empty;

  // ============================================================
  // line sync and edge detect
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q    <= 2'b11;  // idle line is high
      rx_prev_q <= 1'b1;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= sync_q[1];
    end
  end

  assign rx_s       = sync_q[1];
  assign start_edge = rx_prev_q && !rx_s;

  assign half_last = (baud_div_i >> 1) - 1'b1;  // mid start bit
  assign full_last = baud_div_i - 1'b1;
  assign data_smp  = (state_q == uart_pkg::RX_DATA) && (phase_q == full_last);
  assign stop_smp  = (state_q == uart_pkg::RX_STOP) && (phase_q == full_last);

  // ============================================================
  // FSM
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= uart_pkg::RX_IDLE;
      phase_q   <= '0;
      bit_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q  <= 1'b0;
      phase_q <= phase_q + 1'b1;
      if (!en_i) begin
        state_q <= uart_pkg::RX_IDLE;
      end else begin
        case (state_q)
          uart_pkg::RX_IDLE: begin
            phase_q <= '0;
            if (start_edge) state_q <= uart_pkg::RX_START;
          end
          uart_pkg::RX_START: begin
            if (phase_q == half_last) begin
              phase_q   <= '0;
              bit_cnt_q <= '0;
              // high again at mid-bit means a glitch
              state_q   <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
            end
          end
          uart_pkg::RX_DATA: begin
            if (data_smp) begin
              phase_q   <= '0;
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == last_bit) state_q <= uart_pkg::RX_STOP;
            end
          end
          uart_pkg::RX_STOP: begin
            if (stop_smp) begin
              state_q <= uart_pkg::RX_IDLE;
              done_q  <= 1'b1;
            end
          end
          default: state_q <= uart_pkg::RX_IDLE;
        endcase
      end
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (data_smp) shift_q <= {rx_s, shift_q[`UART_DATA_W-1:1]};  // LSB first
    if (stop_smp) stop_q <= rx_s;
  end

  // push or flag one cycle after the stop sample
  assign fifo_wr     = done_q && stop_q && !fifo_full;
  assign frame_err_o = done_q && !stop_q;
  assign overrun_o   = done_q && stop_q && fifo_full;

  assign valid_o = !fifo_empty;
  assign fifo_rd = valid_o && ready_i;

  uart_fifo uart_fifo_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_en_i  (fifo_wr),
    .wr_data_i(shift_q),
    .rd_en_i  (fifo_rd),
    .rd_data_o(data_o),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty)
  );

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(frame_err_o && overrun_o))
    else $error("frame error and overrun in one cycle");

endmodule

// File: src/uart_tx.sv
// UART transmitter, 8N1
// takes a byte on the valid/ready port and sends start, 8 data bits LSB
// first, then stop; one FSM step per baud tick
// ready also rises in the last stop-bit cycle so frames can run back to back

`timescale 1ns/100ps

`include "uart_params.svh"

module uart_tx (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  logic            baud_tick_i,
  input  uart_pkg::byte_t data_i,
  input  logic            valid_i,
  output logic            ready_o,
  output logic            busy_o,  // keeps the baud counter running
  output logic            tx_o
);

  localparam int unsigned bit_cnt_w = $clog2(`UART_DATA_W);
  localparam logic [bit_cnt_w-1:0] last_bit = bit_cnt_w'(`UART_DATA_W - 1);

  uart_pkg::tx_state_e   state_q;
  uart_pkg::byte_t       shift_q;
  logic [bit_cnt_w-1:0]  bit_cnt_q;
  logic                  tx_q;
  logic                  xfer;

  // ============================================================
  // handshake
  // ============================================================
  assign ready_o = en_i && ((state_q == uart_pkg::TX_IDLE) ||
                            (state_q == uart_pkg::TX_STOP && baud_tick_i));
  assign xfer    = valid_i && ready_o;
  assign busy_o  = (state_q != uart_pkg::TX_IDLE);
  assign tx_o    = tx_q;  // registered line

  // ============================================================
  // FSM and shifter
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= uart_pkg::TX_IDLE;
      bit_cnt_q <= '0;
      tx_q      <= 1'b1;
    end else if (!en_i) begin
      state_q <= uart_pkg::TX_IDLE;  // abort any frame
      tx_q    <= 1'b1;
    end else if (xfer) begin
      state_q   <= uart_pkg::TX_START;
      bit_cnt_q <= '0;
      tx_q      <= 1'b0;  // start bit from next cycle
    end else if (baud_tick_i) begin
      case (state_q)
        uart_pkg::TX_START: begin
          state_q <= uart_pkg::TX_DATA;
          tx_q    <= shift_q[0];
        end
        uart_pkg::TX_DATA: begin
          if (bit_cnt_q == last_bit) begin
            state_q <= uart_pkg::TX_STOP;
            tx_q    <= 1'b1;
          end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            tx_q      <= shift_q[1];
          end
        end
        uart_pkg::TX_STOP: state_q <= uart_pkg::TX_IDLE;  // nothing queued
        default:           state_q <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // payload shift register
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      shift_q <= data_i;
    end else if (baud_tick_i && state_q == uart_pkg::TX_DATA) begin
      shift_q <= shift_q >> 1;  // next bit into [0]
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (state_q == uart_pkg::TX_IDLE) |-> tx_o)
    else $error("tx line low while idle");

endmodule

// File: src/uart_baud_gen.sv
// bit-period timer for the UART transmitter
// emits a one-cycle tick every baud_div_i clocks while run_i is high;
// the count restarts from zero whenever run_i drops

`timescale 1ns/100ps

`include "uart_params.svh"

module uart_baud_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`UART_DIV_W-1:0] baud_div_i,  // at least 4 cycles per bit
  input  logic                   run_i,
  output logic                   tick_o
);

  logic [`UART_DIV_W-1:0] cnt_q;

  // last cycle of the period
  assign tick_o = run_i && (cnt_q == baud_div_i - 1'b1);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!run_i || tick_o) begin
      cnt_q <= '0;  // held while idle and wrapped on tick
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// File: src/uart_fifo.sv
// receive byte buffer for the UART core
// circular buffer with first-word-fall-through read: rd_data_o always
// shows the oldest entry, rd_en_i pops it
// writes when full and reads when empty are dropped

`timescale 1ns/100ps

`include "uart_params.svh"

module uart_fifo #(
  parameter int unsigned DEPTH = `UART_FIFO_DEPTH  // power of two
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            wr_en_i,
  input  uart_pkg::byte_t wr_data_i,
  input  logic            rd_en_i,
  output uart_pkg::byte_t rd_data_o,
  output logic            full_o,
  output logic            empty_o
);

  localparam int unsigned addr_w = $clog2(DEPTH);

  uart_pkg::byte_t   mem [DEPTH];
  logic [addr_w:0]   wr_ptr_q;  // extra msb is the wrap flag
  logic [addr_w:0]   rd_ptr_q;
  logic              do_wr;
  logic              do_rd;

  // same index, different wrap flag means full
  assign full_o  = (wr_ptr_q[addr_w] != rd_ptr_q[addr_w]) &&
                   (wr_ptr_q[addr_w-1:0] == rd_ptr_q[addr_w-1:0]);
  assign empty_o = (wr_ptr_q == rd_ptr_q);

  assign do_wr = wr_en_i && !full_o;
  assign do_rd = rd_en_i && !empty_o;

  assign rd_data_o = mem[rd_ptr_q[addr_w-1:0]];  // fall-through

  // ============================================================
  // pointers
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr_q[addr_w-1:0]] <= wr_data_i;
    end
  end

  // the receiver must check full before pushing
  assert property (@(posedge clk_i) disable iff (!rst_ni) wr_en_i |-> !full_o)
    else $error("fifo write while full");

  // consumer side only pops on valid, i.e. not empty
  assert property (@(posedge clk_i) disable iff (!rst_ni) rd_en_i |-> !empty_o)
    else $error("fifo read while empty");

endmodule

// File: src/uart_pkg.sv
// shared types for the UART core
// FSM state encodings for the transmitter and receiver, plus the byte type
// modules refer to these by scoped name, e.g. uart_pkg::byte_t

`include "uart_params.svh"

package uart_pkg;

  // ============================================================
  // payload
  // ============================================================
  typedef logic [`UART_DATA_W-1:0] byte_t;  // one frame of data, LSB sent first

  // ============================================================
  // FSM states
  // ============================================================
  // transmitter, one step per baud tick
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,  // line held high, waiting for a byte
    TX_START = 2'd1,
    TX_DATA  = 2'd2,  // shifting out data bits
    TX_STOP  = 2'd3
  } tx_state_e;

  // receiver, timed from the start edge
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,  // watching for a falling edge
    RX_START = 2'd1,  // half period to mid start bit
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

endpackage

// File: src/uart_params.svh
// build-time constants for the UART core
// include in any file that sizes ports or storage from these values
// the FIFO depth must stay a power of two

`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// ============================================================
// frame and baud
// ============================================================
`define UART_DATA_W 8      // data bits per frame, 8N1

`define UART_DIV_W 16      // clk cycles per bit fit in this width

// ============================================================
// receive buffer
// ============================================================
// entries held before overrun
`define UART_FIFO_DEPTH 8

`endif
